/* verilog.f */
+incdir+.
lm80c_mem_pkg.sv
mem_req_if.sv
clock_enables.sv
system_control.sv
boot_loader.sv
ram_eraser.sv
mem_arbiter.sv
lm80c_mem_top.sv
tb_lm80c_mem.sv

/* tb_lm80c_mem.sv */
`default_nettype none
`timescale 1ns/100ps

`include "lm80c_mem_settings.svh"

module tb_lm80c_mem;
	import lm80c_mem_pkg::*;

	localparam int ACC_W = `MEM_ADDR_W + `DATA_W + 2;
	// Request sources for the reference model
	localparam int SRC_DL     = 0;
	localparam int SRC_ER     = 1;
	localparam int SRC_CPU    = 2;
	localparam int SRC_PTR_LO = 3;
	localparam int SRC_PTR_HI = 4;

	// Packed view of the memory port as {addr, wdata, wr, rd}
	typedef logic [ACC_W-1:0] access_t;

	logic       clk_cpu;
	logic       arst_n;
	logic       ioctl_download;
	logic [7:0] ioctl_index;
	mem_addr_t  ioctl_addr;
	mem_data_t  ioctl_dout;
	logic       ioctl_wr;
	logic       erase_trigger;
	logic       status_reset;
	logic       user_button;
	logic [1:0] pio_port_b;
	cpu_addr_t  cpu_addr;
	mem_data_t  cpu_wdata;
	logic       cpu_rd;
	logic       cpu_wr;
	mem_data_t  cpu_rdata;
	mem_addr_t  mem_addr;
	mem_data_t  mem_wdata;
	logic       mem_wr;
	logic       mem_rd;
	mem_data_t  mem_rdata;
	logic       sys_reset;
	logic       cpu_wait;
	logic       led;
	logic       vdp_ena;
	logic       z80_ena;
	logic       psg_ena;

	logic [15:0] lfsr;
	int          check_count;
	int          mismatch_count;
	int          timeout_count;
	int          wr_count;
	// Expected access set by stimulus and picked up at the next rising edge
	logic        exp_valid;
	access_t     exp_acc;
	string       exp_name;
	logic        pend_valid;
	access_t     pend_acc;
	string       pend_name;

	lm80c_mem_top dut_i (.*);

	initial begin
		clk_cpu = 1'b0;
		forever #50 clk_cpu = ~clk_cpu;
	end

	// ========================================================================
	// Helpers
	// ========================================================================

	// Galois LFSR with taps for a maximal 16 bit sequence
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		int i;
		b = '0;
		for (i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic check(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		check_count++;
		if (expected !== actual) begin
			mismatch_count++;
			$display("MISMATCH %s expected %0h actual %0h at %0t",
				name, expected, actual, $time);
		end
	endtask

	task automatic timed_out(input string what);
		timeout_count++;
		$display("Timeout while waiting for %s at %0t", what, $time);
	endtask

	// Falling edge where all inputs change
	task automatic tick();
		@(negedge clk_cpu);
		exp_valid = 1'b0;
	endtask

	task automatic present(input string name, input access_t acc);
		exp_valid = 1'b1;
		exp_acc   = acc;
		exp_name  = name;
	endtask

	// Memory port one cycle after a request by the memory map rules
	function automatic access_t ref_access(input int src, input logic [7:0] index,
			input mem_addr_t addr, input mem_data_t data, input logic wr,
			input logic rd, input logic rom_en);
		mem_addr_t a;
		mem_addr_t prg_end;
		logic      bank;
		prg_end = `PRG_START_ADDR + addr + 1;
		// RAM bank unless ROM is mapped and the address is in the low 32K
		bank = !rom_en || (addr[`CPU_ADDR_W-1:0] > `ROM_TOP_ADDR);
		case (src)
			SRC_DL: begin
				a = (index == 8'd2) ? `PRG_START_ADDR + addr : `ROM_START_ADDR + addr;
				return {a, data, 2'b10};
			end
			SRC_ER: begin
				a = `ERASE_START_ADDR + addr;
				return {a, 8'h00, 2'b10};
			end
			SRC_CPU: begin
				a = {{(`MEM_ADDR_W - `CPU_ADDR_W - 1){1'b0}}, bank, addr[`CPU_ADDR_W-1:0]};
				return {a, data, wr, rd};
			end
			SRC_PTR_LO: return {mem_addr_t'(`PTR_PROGND_ADDR), prg_end[7:0], 2'b10};
			default:    return {mem_addr_t'(`PTR_PROGND_ADDR + 1), prg_end[15:8], 2'b10};
		endcase
	endfunction

	// ========================================================================
	// Compare process
	// ========================================================================

	always @(posedge clk_cpu) begin
		pend_valid <= exp_valid;
		pend_acc   <= exp_acc;
		pend_name  <= exp_name;
	end

	// Registered outputs are stable at the falling edge
	always @(negedge clk_cpu) begin
		if (pend_valid) begin
			check(pend_name, 64'(pend_acc), 64'({mem_addr, mem_wdata, mem_wr, mem_rd}));
		end
		if (mem_wr) begin
			wr_count++;
		end
	end

	// ========================================================================
	// Stimulus
	// ========================================================================

	initial begin
		logic [7:0] d;
		logic [7:0] last_rdata;
		mem_addr_t  max_off;
		logic [15:0] cpu_list [0:5];
		int         k;
		int         n;
		int         wr_base;
		arst_n         = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		erase_trigger  = 1'b0;
		status_reset   = 1'b0;
		user_button    = 1'b0;
		pio_port_b     = 2'b01;
		cpu_addr       = '0;
		cpu_wdata      = '0;
		cpu_rd         = 1'b0;
		cpu_wr         = 1'b0;
		mem_rdata      = '0;
		exp_valid      = 1'b0;
		exp_acc        = '0;
		exp_name       = "";
		lfsr           = 16'd76;
		check_count    = 0;
		mismatch_count = 0;
		timeout_count  = 0;
		wr_count       = 0;
		repeat (3) @(posedge clk_cpu);
		tick();
		arst_n = 1'b1;
		check("reset sys_reset", 1, sys_reset);
		check("reset cpu_wait", 1, cpu_wait);
		check("reset mem strobes", 0, {mem_wr, mem_rd});

		// Enables at counter phase k after reset release
		for (k = 1; k <= 64; k++) begin
			tick();
			check("vdp_ena period", (k % `VDP_DIV) == 0, vdp_ena);
			check("z80_ena period", (k % `Z80_DIV) == 0, z80_ena);
			check("psg_ena period", (k % `PSG_DIV) == 0, psg_ena);
			check("psg_ena with z80_ena", 1, !psg_ena || z80_ena);
		end

		// ROM image at slot 3
		tick();
		ioctl_download = 1'b1;
		ioctl_index    = 8'd3;
		for (k = 0; k < 16; k++) begin
			tick();
			check("rom load sys_reset", 1, sys_reset);
			check("rom load cpu_wait", 1, cpu_wait);
			rand_byte(d);
			ioctl_wr   = 1'b1;
			ioctl_addr = 25'(k);
			ioctl_dout = d;
			present("rom load write", ref_access(SRC_DL, 8'd3, 25'(k), d, 1, 0, 1));
		end
		tick();
		ioctl_wr       = 1'b0;
		ioctl_download = 1'b0;
		k = 0;
		while (sys_reset && k < 8) begin
			check("sys_reset held until rom_loaded", 0, dut_i.rom_loaded);
			tick();
			k++;
		end
		if (sys_reset) begin
			timed_out("sys_reset to fall after the ROM download");
		end
		check("rom_loaded one cycle after download", 1, k);
		check("cpu_wait after rom load", 0, cpu_wait);
		check("led after rom load", 1, led);

		// BASIC program at slot 2 with its last write below the top offset
		tick();
		ioctl_download = 1'b1;
		ioctl_index    = 8'd2;
		max_off        = '0;
		for (k = 0; k < 13; k++) begin
			tick();
			rand_byte(d);
			ioctl_wr   = 1'b1;
			ioctl_addr = (k == 12) ? 25'd3 : 25'(k);
			ioctl_dout = d;
			if (ioctl_addr > max_off) begin
				max_off = ioctl_addr;
			end
			present("program write", ref_access(SRC_DL, 8'd2, ioctl_addr, d, 1, 0, 1));
		end
		tick();
		ioctl_wr       = 1'b0;
		ioctl_download = 1'b0;
		tick();
		check("cpu_wait during pointer write", 1, cpu_wait);
		present("end pointer low", ref_access(SRC_PTR_LO, 0, max_off, 0, 1, 0, 1));
		tick();
		present("end pointer high", ref_access(SRC_PTR_HI, 0, max_off, 0, 1, 0, 1));
		tick();

		// CPU banking with ROM mapped for the first six and then all RAM
		cpu_list = '{16'h0000, 16'h1234, 16'h7FFF, 16'h8000, 16'hC3A5, 16'hFFFF};
		for (n = 0; n < 12; n++) begin
			tick();
			if (n > 0) begin
				check("cpu_rdata", last_rdata, cpu_rdata);
			end
			rand_byte(d);
			rand_byte(last_rdata);
			pio_port_b = (n < 6) ? 2'b01 : 2'b00;
			cpu_addr   = cpu_list[n % 6];
			cpu_wdata  = d;
			cpu_rd     = (n % 2) == 0;
			cpu_wr     = (n % 2) == 1;
			mem_rdata  = last_rdata;
			present("cpu access", ref_access(SRC_CPU, 0, 25'(cpu_addr), d, cpu_wr, cpu_rd,
				pio_port_b[0]));
		end
		tick();
		check("cpu_rdata", last_rdata, cpu_rdata);
		cpu_rd     = 1'b0;
		cpu_wr     = 1'b0;
		pio_port_b = 2'b01;

		// RAM erase with one zero write per z80_ena
		tick();
		wr_base       = wr_count;
		erase_trigger = 1'b1;
		tick();
		erase_trigger = 1'b0;
		check("erase_busy after trigger", 1, dut_i.erase_busy);
		check("sys_reset while erasing", 1, sys_reset);
		n = 0;
		k = 0;
		while (dut_i.erase_busy && k < `ERASE_WORDS * `Z80_DIV + 64) begin
			if (z80_ena) begin
				present("erase write", ref_access(SRC_ER, 0, 25'(n), 0, 1, 0, 1));
				n++;
			end
			// Retrigger mid sweep must not restart it
			erase_trigger = (n == 100);
			tick();
			k++;
		end
		erase_trigger = 1'b0;
		if (dut_i.erase_busy) begin
			timed_out("erase_busy to fall");
		end
		tick();
		tick();
		check("erase write count", `ERASE_WORDS, wr_count - wr_base);
		check("erase z80_ena count", `ERASE_WORDS, n);
		check("sys_reset after erase", 0, sys_reset);

		// Download and CPU write in the same cycle
		tick();
		ioctl_download = 1'b1;
		ioctl_index    = 8'd3;
		tick();
		rand_byte(d);
		ioctl_wr   = 1'b1;
		ioctl_addr = 25'h40;
		ioctl_dout = d;
		cpu_wr     = 1'b1;
		cpu_addr   = 16'h9000;
		cpu_wdata  = ~d;
		present("download over cpu", ref_access(SRC_DL, 8'd3, 25'h40, d, 1, 0, 1));
		tick();
		ioctl_wr       = 1'b0;
		ioctl_download = 1'b0;
		cpu_wr         = 1'b0;
		repeat (4) tick();

		$display("Checks %0d, mismatches %0d, timeouts %0d",
			check_count, mismatch_count, timeout_count);
		if (mismatch_count == 0 && timeout_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* lm80c_mem_top.sv */
`default_nettype none
`timescale 1ns/100ps

`include "lm80c_mem_settings.svh"

module lm80c_mem_top (
	input  logic                      clk_cpu,
	input  logic                      arst_n,
	// Host download
	input  logic                      ioctl_download,
	input  logic [`IOCTL_INDEX_W-1:0] ioctl_index,
	input  lm80c_mem_pkg::mem_addr_t  ioctl_addr,
	input  lm80c_mem_pkg::mem_data_t  ioctl_dout,
	input  logic                      ioctl_wr,
	// Menu and board controls
	input  logic                      erase_trigger,
	input  logic                      status_reset,
	input  logic                      user_button,
	input  logic [1:0]                pio_port_b,
	// CPU memory bus
	input  lm80c_mem_pkg::cpu_addr_t  cpu_addr,
	input  lm80c_mem_pkg::mem_data_t  cpu_wdata,
	input  logic                      cpu_rd,
	input  logic                      cpu_wr,
	output lm80c_mem_pkg::mem_data_t  cpu_rdata,
	// Memory device
	output lm80c_mem_pkg::mem_addr_t  mem_addr,
	output lm80c_mem_pkg::mem_data_t  mem_wdata,
	output logic                      mem_wr,
	output logic                      mem_rd,
	input  lm80c_mem_pkg::mem_data_t  mem_rdata,
	// System
	output logic                      sys_reset,
	output logic                      cpu_wait,
	output logic                      led,
	output logic                      vdp_ena,
	output logic                      z80_ena,
	output logic                      psg_ena
);

	logic rom_loaded;
	logic downloading;
	logic erase_busy;

	mem_req_if dl_req ();
	mem_req_if er_req ();
	mem_req_if cpu_req ();

	// CPU request, bank bits set by the arbiter
	assign cpu_req.addr  = {{(`MEM_ADDR_W - `CPU_ADDR_W){1'b0}}, cpu_addr};
	assign cpu_req.wdata = cpu_wdata;
	assign cpu_req.wr    = cpu_wr;
	assign cpu_req.rd    = cpu_rd;

	// Read data goes straight back to the CPU
	assign cpu_rdata = mem_rdata;

	clock_enables clock_enables_i (
		.clk_cpu (clk_cpu),
		.arst_n  (arst_n),
		.vdp_ena (vdp_ena),
		.z80_ena (z80_ena),
		.psg_ena (psg_ena)
	);

	system_control system_control_i (
		.rom_loaded   (rom_loaded),
		.downloading  (downloading),
		.erase_busy   (erase_busy),
		.status_reset (status_reset),
		.user_button  (user_button),
		.pio_port_b   (pio_port_b),
		.sys_reset    (sys_reset),
		.cpu_wait     (cpu_wait),
		.led          (led)
	);

	boot_loader boot_loader_i (
		.clk_cpu        (clk_cpu),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.req            (dl_req.requester),
		.downloading    (downloading),
		.rom_loaded     (rom_loaded)
	);

	ram_eraser ram_eraser_i (
		.clk_cpu       (clk_cpu),
		.arst_n        (arst_n),
		.z80_ena       (z80_ena),
		.erase_trigger (erase_trigger),
		.req           (er_req.requester),
		.erase_busy    (erase_busy)
	);

	// PIO B bit 0 maps ROM into the low 32K
	mem_arbiter mem_arbiter_i (
		.clk_cpu     (clk_cpu),
		.arst_n      (arst_n),
		.dl_req      (dl_req.arbiter),
		.er_req      (er_req.arbiter),
		.cpu_req     (cpu_req.arbiter),
		.downloading (downloading),
		.erase_busy  (erase_busy),
		.rom_enabled (pio_port_b[0]),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.mem_wr      (mem_wr),
		.mem_rd      (mem_rd)
	);

endmodule

`default_nettype wire

/* mem_arbiter.sv */
`default_nettype none
`timescale 1ns/100ps

`include "lm80c_mem_settings.svh"

module mem_arbiter (
	input  logic                     clk_cpu,
	input  logic                     arst_n,
	mem_req_if.arbiter               dl_req,
	mem_req_if.arbiter               er_req,
	mem_req_if.arbiter               cpu_req,
	input  logic                     downloading,
	input  logic                     erase_busy,
	input  logic                     rom_enabled,
	output lm80c_mem_pkg::mem_addr_t mem_addr,
	output lm80c_mem_pkg::mem_data_t mem_wdata,
	output logic                     mem_wr,
	output logic                     mem_rd
);
	import lm80c_mem_pkg::*;

	localparam cpu_addr_t ROM_TOP = cpu_addr_t'(`ROM_TOP_ADDR);

	mem_addr_t sel_addr;
	mem_data_t sel_wdata;
	logic      sel_wr;
	logic      sel_rd;
	logic      ram_bank;

	// ========================================================================
	// Banking
	// ========================================================================

	// ROM at 0-0000..0-7FFF and RAM at 1-0000..1-FFFF
	// With ROM off, the CPU sees RAM everywhere
	assign ram_bank = ~rom_enabled | (cpu_req.addr[`CPU_ADDR_W-1:0] > ROM_TOP);

	// ========================================================================
	// Requester select
	// ========================================================================

	always_comb begin
		if (downloading && dl_req.wr) begin
			// Host download wins
			sel_addr  = dl_req.addr;
			sel_wdata = dl_req.wdata;
			sel_wr    = 1'b1;
			sel_rd    = 1'b0;
		end else if (erase_busy) begin
			sel_addr  = er_req.addr;
			sel_wdata = er_req.wdata;
			sel_wr    = er_req.wr;
			sel_rd    = 1'b0;
		end else begin
			// CPU gets the bank bit above its 64K window
			sel_addr              = cpu_req.addr;
			sel_addr[`CPU_ADDR_W] = ram_bank;
			sel_wdata             = cpu_req.wdata;
			sel_wr                = cpu_req.wr;
			sel_rd                = cpu_req.rd;
		end
	end

	// Strobes cleared on reset
	always_ff @(posedge clk_cpu or negedge arst_n) begin
		if (!arst_n) begin
			mem_wr <= 1'b0;
			mem_rd <= 1'b0;
		end else begin
			mem_wr <= sel_wr;
			mem_rd <= sel_rd;
		end
	end

	// Address and data follow the strobes
	always_ff @(posedge clk_cpu) begin
		mem_addr  <= sel_addr;
		mem_wdata <= sel_wdata;
	end

	// Only the CPU reads, so a read cycle must not carry a write
	ap_cpu_rd_wr: assert property (@(posedge clk_cpu) disable iff (!arst_n)
		mem_rd |-> !mem_wr);

endmodule

`default_nettype wire

/* ram_eraser.sv */
`default_nettype none
`timescale 1ns/100ps

`include "lm80c_mem_settings.svh"

module ram_eraser (
	input  logic         clk_cpu,
	input  logic         arst_n,
	input  logic         z80_ena,
	input  logic         erase_trigger,
	mem_req_if.requester req,
	output logic         erase_busy
);
	import lm80c_mem_pkg::*;

	localparam int CNT_W = $clog2(`ERASE_WORDS);
	localparam mem_addr_t ERASE_BASE = mem_addr_t'(`ERASE_START_ADDR);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`ERASE_WORDS - 1);

	eraser_state_e    state;
	// Offset of the next byte to clear
	logic [CNT_W-1:0] erase_cnt;

	// ========================================================================
	// Sweep FSM
	// ========================================================================

	always_ff @(posedge clk_cpu or negedge arst_n) begin
		if (!arst_n) begin
			state     <= er_idle;
			erase_cnt <= '0;
		end else begin
			case (state)
				er_idle: begin
					// Retrigger while sweeping has no effect
					if (erase_trigger) begin
						state     <= er_sweep;
						erase_cnt <= '0;
					end
				end
				default: begin
					// One byte per CPU tick
					if (z80_ena) begin
						erase_cnt <= erase_cnt + 1'b1;
						if (erase_cnt == LAST_CNT) begin
							state <= er_idle;
						end
					end
				end
			endcase
		end
	end

	assign erase_busy = (state == er_sweep);

	// Zero writes only, never reads
	assign req.addr  = ERASE_BASE + mem_addr_t'(erase_cnt);
	assign req.wdata = '0;
	assign req.wr    = erase_busy & z80_ena;
	assign req.rd    = 1'b0;

	// Busy ends right after the write to the last byte of the bank
	ap_last_write: assert property (@(posedge clk_cpu) disable iff (!arst_n)
		$fell(erase_busy) |->
			$past(req.wr) && ($past(req.addr) == ERASE_BASE + mem_addr_t'(LAST_CNT)));

endmodule

`default_nettype wire

/* boot_loader.sv */
`default_nettype none
`timescale 1ns/100ps

`include "lm80c_mem_settings.svh"

module boot_loader (
	input  logic                      clk_cpu,
	input  logic                      arst_n,
	input  logic                      ioctl_download,
	input  logic [`IOCTL_INDEX_W-1:0] ioctl_index,
	input  lm80c_mem_pkg::mem_addr_t  ioctl_addr,
	input  lm80c_mem_pkg::mem_data_t  ioctl_dout,
	input  logic                      ioctl_wr,
	mem_req_if.requester              req,
	output logic                      downloading,
	output logic                      rom_loaded
);
	import lm80c_mem_pkg::*;

	localparam mem_addr_t ROM_BASE = mem_addr_t'(`ROM_START_ADDR);
	localparam mem_addr_t PRG_BASE = mem_addr_t'(`PRG_START_ADDR);
	localparam mem_addr_t PTR_ADDR = mem_addr_t'(`PTR_PROGND_ADDR);

	loader_state_e state;
	dl_kind_e      dl_kind;
	dl_kind_e      kind_q;
	mem_addr_t     max_off;
	mem_addr_t     prg_end;
	logic          host_wr;
	logic          prg_wr;

	// Slot decode
	always_comb begin
		case (ioctl_index)
			`IOCTL_INDEX_W'(dl_boot): dl_kind = dl_boot;
			`IOCTL_INDEX_W'(dl_prg):  dl_kind = dl_prg;
			`IOCTL_INDEX_W'(dl_rom):  dl_kind = dl_rom;
			default:                  dl_kind = dl_none;
		endcase
	end

	// Host writes to unknown slots are dropped
	assign host_wr = ioctl_download & ioctl_wr & (dl_kind != dl_none);
	assign prg_wr  = host_wr & (dl_kind == dl_prg);

	// ========================================================================
	// Load sequencing
	// ========================================================================

	always_ff @(posedge clk_cpu or negedge arst_n) begin
		if (!arst_n) begin
			state      <= ld_idle;
			kind_q     <= dl_none;
			rom_loaded <= 1'b0;
		end else begin
			// Keep the kind of the running download for its end
			if (ioctl_download) begin
				kind_q <= dl_kind;
			end
			case (state)
				ld_idle: begin
					if (ioctl_download) begin
						state <= ld_load;
					end
				end
				ld_load: begin
					if (!ioctl_download) begin
						if (kind_q == dl_prg) begin
							state <= ld_ptr_lo;
						end else begin
							state <= ld_idle;
							// Boot or ROM image done, sticky until reset
							if (kind_q != dl_none) begin
								rom_loaded <= 1'b1;
							end
						end
					end
				end
				ld_ptr_lo: state <= ld_ptr_hi;
				default:   state <= ld_idle;
			endcase
		end
	end

	// Highest program offset, restarts with every download
	always_ff @(posedge clk_cpu) begin
		if (prg_wr && (state == ld_idle || ioctl_addr > max_off)) begin
			max_off <= ioctl_addr;
		end else if (state == ld_idle) begin
			max_off <= '0;
		end
	end

	// First free byte after the program
	assign prg_end = PRG_BASE + max_off + 1'b1;

	// Pointer writes still count as download for the arbiter
	assign downloading = ioctl_download | (state == ld_ptr_lo) | (state == ld_ptr_hi);

	// ========================================================================
	// Memory request
	// ========================================================================

	always_comb begin
		req.rd    = 1'b0;
		req.wr    = host_wr;
		req.wdata = ioctl_dout;
		req.addr  = (dl_kind == dl_prg) ? PRG_BASE + ioctl_addr : ROM_BASE + ioctl_addr;
		case (state)
			ld_ptr_lo: begin
				// Low byte first, Z80 order
				req.wr    = 1'b1;
				req.addr  = PTR_ADDR;
				req.wdata = prg_end[`DATA_W-1:0];
			end
			ld_ptr_hi: begin
				req.wr    = 1'b1;
				req.addr  = PTR_ADDR + 1'b1;
				req.wdata = prg_end[2*`DATA_W-1:`DATA_W];
			end
			default: ;
		endcase
	end

	// Host has to raise download at least a cycle before its first write
	ap_no_wr_idle: assert property (@(posedge clk_cpu) disable iff (!arst_n)
		(state == ld_idle) |-> !$rose(req.wr));

endmodule

`default_nettype wire

/* system_control.sv */
`default_nettype none
`timescale 1ns/100ps

module system_control (
	input  logic       rom_loaded,
	input  logic       downloading,
	input  logic       erase_busy,
	input  logic       status_reset,
	input  logic       user_button,
	input  logic [1:0] pio_port_b,
	output logic       sys_reset,
	output logic       cpu_wait,
	output logic       led
);

	// ========================================================================
	// Reset and wait
	// ========================================================================

	// Hold the machine in reset until the ROM image is in memory
	// Erasing also counts as reset, the CPU must not touch RAM then
	// Menu reset and the board button act the same
	always_comb begin
		sys_reset = ~rom_loaded | erase_busy | status_reset | user_button;
	end

	// Stall the CPU during boot and any host download
	always_comb begin
		cpu_wait = ~rom_loaded | downloading;
	end

	// ========================================================================
	// Activity LED
	// ========================================================================

	// Bit 1 of PIO port B switches the LED off under software control
	// Bit 0 selects ROM banking and is used by the arbiter
	always_comb begin
		led = ~(cpu_wait | pio_port_b[1]);
	end

endmodule

`default_nettype wire

/* clock_enables.sv */
`default_nettype none
`timescale 1ns/100ps

`include "lm80c_mem_settings.svh"

module clock_enables (
	input  logic clk_cpu,
	input  logic arst_n,
	output logic vdp_ena,
	output logic z80_ena,
	output logic psg_ena
);

	localparam int CNT_W = $clog2(`PSG_DIV);

	// Shared phase counter for all three sections
	logic [CNT_W-1:0] div_cnt;

	always_ff @(posedge clk_cpu or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt <= '0;
		end else if (div_cnt == CNT_W'(`PSG_DIV - 1)) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// All enables fire on phase zero, so they line up after reset
	assign vdp_ena = (div_cnt % `VDP_DIV) == 0;
	assign z80_ena = (div_cnt % `Z80_DIV) == 0;
	assign psg_ena = (div_cnt == '0);

	// PSG ticks only on a CPU tick
	ap_psg_in_z80: assert property (@(posedge clk_cpu) disable iff (!arst_n)
		psg_ena |-> z80_ena && vdp_ena);

	// CPU enable period holds exactly
	ap_z80_period: assert property (@(posedge clk_cpu) disable iff (!arst_n)
		z80_ena |=> !z80_ena [*(`Z80_DIV - 1)] ##1 z80_ena);

endmodule

`default_nettype wire

/* mem_req_if.sv */
`default_nettype none
`timescale 1ns/100ps

`include "lm80c_mem_settings.svh"

interface mem_req_if;
	import lm80c_mem_pkg::*;

	// One memory access per cycle, no ready
	mem_addr_t addr;
	mem_data_t wdata;
	logic      wr;
	logic      rd;

	// Loader, eraser and CPU side
	modport requester (
		output addr,
		output wdata,
		output wr,
		output rd
	);

	// Arbiter side
	modport arbiter (
		input addr,
		input wdata,
		input wr,
		input rd
	);

endinterface

`default_nettype wire

/* lm80c_mem_pkg.sv */
`default_nettype none

`include "lm80c_mem_settings.svh"

package lm80c_mem_pkg;

	// Address and data words
	typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;
	typedef logic [`DATA_W-1:0]     mem_data_t;
	typedef logic [`CPU_ADDR_W-1:0] cpu_addr_t;

	// Download slot kinds, values match the host index
	typedef enum logic [1:0] {
		dl_boot = 2'd0,
		dl_none = 2'd1,
		dl_prg  = 2'd2,
		dl_rom  = 2'd3
	} dl_kind_e;

	// Boot loader FSM
	typedef enum logic [1:0] {
		ld_idle,
		ld_load,
		ld_ptr_lo,
		ld_ptr_hi
	} loader_state_e;

	// RAM eraser FSM
	typedef enum logic {
		er_idle,
		er_sweep
	} eraser_state_e;

endpackage

`default_nettype wire

/* lm80c_mem_settings.svh */
`ifndef LM80C_MEM_SETTINGS_SVH
`define LM80C_MEM_SETTINGS_SVH

// ========================================================================
// Widths
// ========================================================================

// Memory device address, covers ROM and RAM banks
`define MEM_ADDR_W 25
`define DATA_W 8
// Z80 address bus
`define CPU_ADDR_W 16
// Host download slot number
`define IOCTL_INDEX_W 8

// ========================================================================
// Clock enable periods in clk_cpu cycles
// ========================================================================

`define VDP_DIV 4
`define Z80_DIV 8
`define PSG_DIV 16

// ========================================================================
// Memory map
// ========================================================================

// ROM images start at the bottom of bank 0
`define ROM_START_ADDR 25'h00000
// BASIC text area in bank 1
`define PRG_START_ADDR 25'h15608
// Two-byte end of program pointer used by BASIC
`define PTR_PROGND_ADDR 25'h155E4
// Eraser clears the whole RAM bank
`define ERASE_START_ADDR 25'h10000
`define ERASE_WORDS 65536
// Highest CPU address that may hit ROM
`define ROM_TOP_ADDR 16'h7FFF

`endif
